//--- src/l2_axi_defs.svh
/* l2 to axi bridge parameters */
`ifndef L2_AXI_DEFS_SVH
`define L2_AXI_DEFS_SVH

// bus widths
`define ADDR_W          32
`define DATA_W          32

// cache line geometry
`define LINE_WORDS      4
`define WOFF_W          2                   // log2 of LINE_WORDS
`define LINE_W          128                 // LINE_WORDS * DATA_W

// axsize code, 4 bytes per beat
`define AXI_SIZE_WORD   3'd2

`endif

//--- src/axi_pkg.sv
/* axi side types */
package axi_pkg;

    // axburst encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,                // the only kind the bridge issues
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // xresp encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- src/l2_pkg.sv
/* l2 side types */
`include "l2_axi_defs.svh"

package l2_pkg;

    // request address, seen whole or split into line fields
    typedef union packed {
        logic [`ADDR_W-1:0] byte_addr;
        struct packed {
            logic [`ADDR_W-`WOFF_W-3:0] line_no;
            logic [`WOFF_W-1:0]         word_off;
            logic [1:0]                 byte_off;   // byte within a 32 bit word
        } line;
    } l2_addr_u;

    // read engine
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,                     // ar held until arready
        RD_DATA = 2'd2                      // taking r beats
    } rd_state_e;

    // write engine
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3                      // waiting on b
    } wr_state_e;

endpackage

//--- src/l2_req_decode.sv
/* l2 request decode */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module l2_req_decode (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rd_req,
    input  logic [`ADDR_W-1:0]   rd_addr,
    input  logic                 wr_req,
    input  logic [`ADDR_W-1:0]   wr_addr,
    input  logic [`LINE_W-1:0]   wr_line,
    input  logic                 rd_done,
    input  logic                 wr_done,
    output logic                 rd_busy,
    output logic                 wr_busy,
    output logic                 rd_cmd,
    output logic [`ADDR_W-1:0]   rd_base,
    output logic [`WOFF_W-1:0]   rd_woff,
    output logic [7:0]           rd_len,
    output logic                 wr_cmd,
    output logic [`ADDR_W-1:0]   wr_base,
    output logic [7:0]           wr_len,
    output logic [`LINE_W-1:0]   wr_line_q
);
    import l2_pkg::*;

    l2_addr_u rd_a, wr_a;           // raw request addresses
    l2_addr_u rd_a_base, wr_a_base; // same, offsets dropped

    assign rd_a = rd_addr;
    assign wr_a = wr_addr;

    always_comb begin
        rd_a_base = rd_a;
        rd_a_base.line.word_off = '0;
        rd_a_base.line.byte_off = '0;
        wr_a_base = wr_a;
        wr_a_base.line.word_off = '0;
        wr_a_base.line.byte_off = '0;
    end

    // command strobes and busy flags
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_cmd  <= 1'b0;
            wr_cmd  <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            rd_cmd <= rd_req;
            wr_cmd <= wr_req;
            if (rd_req)       rd_busy <= 1'b1;
            else if (rd_done) rd_busy <= 1'b0;
            if (wr_req)       wr_busy <= 1'b1;
            else if (wr_done) wr_busy <= 1'b0;
        end
    end

    // payload, held until the next request on that channel
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_base <= rd_a_base.byte_addr;
            rd_woff <= rd_a.line.word_off;      // critical word
            rd_len  <= 8'(`LINE_WORDS - 1);
        end
        if (wr_req) begin
            wr_base   <= wr_a_base.byte_addr;
            wr_len    <= 8'(`LINE_WORDS - 1);
            wr_line_q <= wr_line;
        end
    end

    // cache must wait for busy to drop
    a_rd_not_busy: assert property (@(posedge clk) disable iff (!rstn) rd_req |-> !rd_busy)
        else $error("read request while read channel busy");
    a_wr_not_busy: assert property (@(posedge clk) disable iff (!rstn) wr_req |-> !wr_busy)
        else $error("write request while write channel busy");

endmodule

//--- src/axi_rd_engine.sv
/* axi read engine */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module axi_rd_engine (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rd_cmd,
    input  logic [`ADDR_W-1:0]   rd_base,
    input  logic [7:0]           rd_len,
    input  logic                 arready,
    input  logic [`DATA_W-1:0]   rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    input  logic                 rlast,
    output logic [`ADDR_W-1:0]   araddr,
    output logic                 arvalid,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic [1:0]           arburst,
    output logic                 rready,
    output logic                 beat_vld,
    output logic [`DATA_W-1:0]   beat_data,
    output logic [1:0]           beat_resp,
    output logic                 beat_last
);
    import l2_pkg::*;
    import axi_pkg::*;

    localparam logic [`WOFF_W:0] LAST_BEAT = `LINE_WORDS - 1;

    rd_state_e        rd_cur, rd_nxt;
    logic [`WOFF_W:0] beat_cnt;         // beats accepted in this burst
    logic             r_hs;

    assign r_hs = rvalid && rready;

    always_ff @(posedge clk) begin
        if (!rstn) rd_cur <= RD_IDLE;
        else       rd_cur <= rd_nxt;
    end

    always_comb begin
        rd_nxt = rd_cur;
        case (rd_cur)
            RD_IDLE: if (rd_cmd)         rd_nxt = RD_ADDR;
            RD_ADDR: if (arready)        rd_nxt = RD_DATA;
            RD_DATA: if (r_hs && rlast)  rd_nxt = RD_IDLE;
            default:                     rd_nxt = RD_IDLE;
        endcase
    end

    // ar payload latched with the command, stable while arvalid waits
    always_ff @(posedge clk) begin
        if (rd_cur == RD_IDLE && rd_cmd) begin
            araddr <= rd_base;
            arlen  <= rd_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)                               beat_cnt <= '0;
        else if (rd_cur == RD_ADDR && arready)   beat_cnt <= '0;
        else if (r_hs)                           beat_cnt <= beat_cnt + 1'b1;
    end

    assign arvalid = (rd_cur == RD_ADDR);
    assign arsize  = `AXI_SIZE_WORD;
    assign arburst = BURST_INCR;
    assign rready  = (rd_cur == RD_DATA);

    // accepted beats go on to the collector
    assign beat_vld  = r_hs;
    assign beat_data = rdata;
    assign beat_resp = rresp;
    assign beat_last = rlast;

    // the slave must end the burst on the last word of the line
    a_rlast_pos: assert property (@(posedge clk) disable iff (!rstn)
        r_hs |-> (rlast == (beat_cnt == LAST_BEAT)))
        else $error("rlast not on beat %0d", `LINE_WORDS);

endmodule

//--- src/axi_wr_engine.sv
/* axi write engine */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module axi_wr_engine (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_cmd,
    input  logic [`ADDR_W-1:0]     wr_base,
    input  logic [7:0]             wr_len,
    input  logic [`LINE_W-1:0]     wr_line_q,
    input  logic                   awready,
    input  logic                   wready,
    input  logic [1:0]             bresp,
    input  logic                   bvalid,
    output logic [`ADDR_W-1:0]     awaddr,
    output logic                   awvalid,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [`DATA_W-1:0]     wdata,
    output logic [`DATA_W/8-1:0]   wstrb,
    output logic                   wvalid,
    output logic                   wlast,
    output logic                   bready,
    output logic                   b_vld,
    output logic [1:0]             b_resp
);
    import l2_pkg::*;
    import axi_pkg::*;

    wr_state_e          wr_cur, wr_nxt;
    logic [`LINE_W-1:0] line_sr;        // words still to send, next one at the bottom
    logic [7:0]         wcnt;           // beats accepted so far
    logic               w_hs;

    assign w_hs = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rstn) wr_cur <= WR_IDLE;
        else       wr_cur <= wr_nxt;
    end

    always_comb begin
        wr_nxt = wr_cur;
        case (wr_cur)
            WR_IDLE: if (wr_cmd)        wr_nxt = WR_ADDR;
            WR_ADDR: if (awready)       wr_nxt = WR_DATA;
            WR_DATA: if (w_hs && wlast) wr_nxt = WR_RESP;
            WR_RESP: if (bvalid)        wr_nxt = WR_IDLE;
            default:                    wr_nxt = WR_IDLE;
        endcase
    end

    // aw payload and the line to stream
    always_ff @(posedge clk) begin
        if (wr_cur == WR_IDLE && wr_cmd) begin
            awaddr  <= wr_base;
            awlen   <= wr_len;
            line_sr <= wr_line_q;
        end else if (w_hs) begin
            line_sr <= line_sr >> `DATA_W;  // lowest word goes first
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)                              wcnt <= '0;
        else if (wr_cur == WR_ADDR && awready)  wcnt <= '0;
        else if (w_hs)                          wcnt <= wcnt + 8'd1;
    end

    assign awvalid = (wr_cur == WR_ADDR);
    assign awsize  = `AXI_SIZE_WORD;
    assign awburst = BURST_INCR;

    assign wvalid = (wr_cur == WR_DATA);
    assign wdata  = line_sr[`DATA_W-1:0];
    assign wstrb  = '1;                     // full line, every byte
    assign wlast  = (wr_cur == WR_DATA) && (wcnt == awlen);

    assign bready = (wr_cur == WR_RESP);
    assign b_vld  = bvalid && bready;
    assign b_resp = bresp;

    // a new command only once the last burst is closed
    a_cmd_idle: assert property (@(posedge clk) disable iff (!rstn)
        wr_cmd |-> (wr_cur == WR_IDLE))
        else $error("write command while write engine busy");

endmodule

//--- src/l2_resp_collect.sv
/* response collection */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module l2_resp_collect (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 beat_vld,
    input  logic [`DATA_W-1:0]   beat_data,
    input  logic [1:0]           beat_resp,
    input  logic                 beat_last,
    input  logic [`WOFF_W-1:0]   rd_woff,
    input  logic                 b_vld,
    input  logic [1:0]           b_resp,
    output logic                 rd_done,
    output logic [`LINE_W-1:0]   rd_line,
    output logic [`DATA_W-1:0]   rd_word,
    output logic                 rd_err,
    output logic                 wr_done,
    output logic                 wr_err
);
    import axi_pkg::*;

    logic err_acc;                      // bad response seen earlier in this burst
    logic beat_bad;

    assign beat_bad = (beat_resp != RESP_OKAY);

    // beats shift in from the top, first one ends up as word 0
    always_ff @(posedge clk) begin
        if (beat_vld)
            rd_line <= {beat_data, rd_line[`LINE_W-1:`DATA_W]};
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_done <= 1'b0;
            rd_err  <= 1'b0;
            err_acc <= 1'b0;
            wr_done <= 1'b0;
            wr_err  <= 1'b0;
        end else begin
            rd_done <= beat_vld && beat_last;
            if (beat_vld) begin
                err_acc <= beat_last ? 1'b0 : (err_acc | beat_bad);
                if (beat_last)
                    rd_err <= err_acc | beat_bad;
            end
            wr_done <= b_vld;
            if (b_vld)
                wr_err <= (b_resp != RESP_OKAY);
        end
    end

    assign rd_word = rd_line[rd_woff*`DATA_W +: `DATA_W];   // critical word

endmodule

//--- src/l2_axi_bridge.sv
/* l2 cache to axi bridge */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module l2_axi_bridge (
    input  logic                   clk,
    input  logic                   rstn,
    // l2 side
    input  logic                   rd_req,
    input  logic [`ADDR_W-1:0]     rd_addr,
    input  logic                   wr_req,
    input  logic [`ADDR_W-1:0]     wr_addr,
    input  logic [`LINE_W-1:0]     wr_line,
    output logic                   rd_busy,
    output logic                   wr_busy,
    output logic                   rd_done,
    output logic [`LINE_W-1:0]     rd_line,
    output logic [`DATA_W-1:0]     rd_word,
    output logic                   rd_err,
    output logic                   wr_done,
    output logic                   wr_err,
    // ar / r
    output logic [`ADDR_W-1:0]     araddr,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    input  logic [`DATA_W-1:0]     rdata,
    input  logic [1:0]             rresp,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic                   rlast,
    // aw / w / b
    output logic [`ADDR_W-1:0]     awaddr,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [`DATA_W-1:0]     wdata,
    output logic [`DATA_W/8-1:0]   wstrb,
    output logic                   wvalid,
    input  logic                   wready,
    output logic                   wlast,
    input  logic [1:0]             bresp,
    input  logic                   bvalid,
    output logic                   bready
);
    logic                 rd_cmd, wr_cmd;
    logic [`ADDR_W-1:0]   rd_base, wr_base;
    logic [`WOFF_W-1:0]   rd_woff;
    logic [7:0]           rd_len, wr_len;
    logic [`LINE_W-1:0]   wr_line_q;
    logic                 beat_vld, beat_last, b_vld;
    logic [`DATA_W-1:0]   beat_data;
    logic [1:0]           beat_resp, b_resp;

    l2_req_decode u_decode (
        .clk, .rstn, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_line,
        .rd_done, .wr_done, .rd_busy, .wr_busy,
        .rd_cmd, .rd_base, .rd_woff, .rd_len,
        .wr_cmd, .wr_base, .wr_len, .wr_line_q
    );

    axi_rd_engine u_rd (
        .clk, .rstn, .rd_cmd, .rd_base, .rd_len,
        .arready, .rdata, .rresp, .rvalid, .rlast,
        .araddr, .arvalid, .arlen, .arsize, .arburst, .rready,
        .beat_vld, .beat_data, .beat_resp, .beat_last
    );

    axi_wr_engine u_wr (
        .clk, .rstn, .wr_cmd, .wr_base, .wr_len, .wr_line_q,
        .awready, .wready, .bresp, .bvalid,
        .awaddr, .awvalid, .awlen, .awsize, .awburst,
        .wdata, .wstrb, .wvalid, .wlast, .bready, .b_vld, .b_resp
    );

    l2_resp_collect u_collect (
        .clk, .rstn, .beat_vld, .beat_data, .beat_resp, .beat_last, .rd_woff,
        .b_vld, .b_resp, .rd_done, .rd_line, .rd_word, .rd_err, .wr_done, .wr_err
    );

endmodule

//--- bench/axi_mem_model.sv
/* axi slave memory model */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module axi_mem_model (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`ADDR_W-1:0]   araddr,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [7:0]           arlen,
    output logic [`DATA_W-1:0]   rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output logic                 rlast,
    input  logic [`ADDR_W-1:0]   awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [`DATA_W-1:0]   wdata,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic                 wlast,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready
);
    import axi_pkg::*;

    logic [31:0]        lfsr;
    logic [`DATA_W-1:0] mem [logic [`ADDR_W-3:0]];     // written words only
    logic [`ADDR_W-1:0] ra, wa;                         // next beat address per channel
    logic [7:0]         rcnt, rlen;
    logic               rd_act, wr_act;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // unwritten words read back as their own address
    function automatic logic [`DATA_W-1:0] word_at(input logic [`ADDR_W-1:0] a);
        return mem.exists(a[`ADDR_W-1:2]) ? mem[a[`ADDR_W-1:2]] : {a[`ADDR_W-1:2], 2'b00};
    endfunction

    always @(posedge clk) begin : model
        logic [31:0]        s;
        logic [3:0]         rnd;
        logic               r_hs;
        logic [`ADDR_W-1:0] na;
        logic [7:0]         nc;
        s = lfsr;
        for (int i = 0; i < 4; i++) begin
            s = lfsr_step(s);                           // one step per bit taken
            rnd[i] = s[0];
        end
        r_hs = rvalid && rready;
        na = r_hs ? ra + 4 : ra;
        nc = r_hs ? rcnt + 8'd1 : rcnt;
        if (!rstn) begin
            lfsr    <= 32'h5355_e6af;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rd_act  <= 1'b0;
            wr_act  <= 1'b0;
        end else begin
            lfsr <= s;
            // read side, one burst at a time
            arready <= !rd_act && !(arvalid && arready) && rnd[0];
            if (arvalid && arready) begin
                rd_act <= 1'b1;
                ra     <= araddr;
                rcnt   <= '0;
                rlen   <= arlen;
            end
            if (r_hs) begin
                ra   <= na;
                rcnt <= nc;
            end
            if (rd_act && !(r_hs && rlast) && (!rvalid || r_hs)) begin
                rvalid <= rnd[1];                       // beat held once valid is up
                rdata  <= word_at(na);
                rresp  <= na[31] ? RESP_SLVERR : RESP_OKAY;
                rlast  <= (nc == rlen);
            end else if (r_hs) begin
                rvalid <= 1'b0;                         // last beat taken
                rlast  <= 1'b0;
                rd_act <= 1'b0;
            end
            // write side
            awready <= !wr_act && !(awvalid && awready) && rnd[2];
            if (awvalid && awready) begin
                wr_act <= 1'b1;
                wa     <= awaddr;
            end
            wready <= wr_act && !bvalid && !(wvalid && wready && wlast) && rnd[3];
            if (wvalid && wready) begin
                mem[wa[`ADDR_W-1:2]] = wdata;
                wa <= wa + 4;
                if (wlast) begin
                    bvalid <= 1'b1;
                    bresp  <= wa[31] ? RESP_SLVERR : RESP_OKAY;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                wr_act <= 1'b0;
            end
        end
    end

endmodule

//--- bench/tb_l2_axi_bridge.sv
/* l2 to axi bridge testbench */
`timescale 1ns/1ps
`include "l2_axi_defs.svh"

module tb_l2_axi_bridge;

    localparam int TIMEOUT = 200;       // cycles per wait

    logic                 clk, rstn;
    logic                 rd_req, wr_req;
    logic [`ADDR_W-1:0]   rd_addr, wr_addr;
    logic [`LINE_W-1:0]   wr_line, rd_line;
    logic [`DATA_W-1:0]   rd_word;
    logic                 rd_busy, wr_busy, rd_done, wr_done, rd_err, wr_err;
    logic [`ADDR_W-1:0]   araddr, awaddr;
    logic [`DATA_W-1:0]   rdata, wdata;
    logic [7:0]           arlen, awlen;
    logic [2:0]           arsize, awsize;
    logic [1:0]           arburst, awburst, rresp, bresp;
    logic [`DATA_W/8-1:0] wstrb;
    logic                 arvalid, arready, rvalid, rready, rlast;
    logic                 awvalid, awready, wvalid, wready, wlast, bvalid, bready;

    // expected results of the operation in flight
    logic [`LINE_W-1:0]   exp_line;
    logic [`DATA_W-1:0]   exp_word;
    logic                 exp_rd_err, exp_wr_err;

    l2_axi_bridge u_dut (.*);
    axi_mem_model u_mem (.*);

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic compare(input string name, input logic [`LINE_W-1:0] got,
                           input logic [`LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_idle(input logic want_rd, input logic want_wr);
        int n;
        n = 0;
        while ((want_rd && rd_busy) || (want_wr && wr_busy)) begin
            if (n == TIMEOUT) begin
                $display("timed out waiting for the busy flag to fall");
                stop_run();
            end
            n++;
            @(negedge clk);
        end
    endtask

    // busy must still be high at the done strobe and low one cycle later
    task automatic wait_done(input logic want_rd, input logic want_wr);
        logic got_rd, got_wr, chk_rd, chk_wr;
        int   n;
        got_rd = !want_rd;
        got_wr = !want_wr;
        chk_rd = 1'b0;
        chk_wr = 1'b0;
        n = 0;
        while (!(got_rd && got_wr) || chk_rd || chk_wr) begin
            if (chk_rd) begin
                compare("rd_busy", rd_busy, 1'b0);
                chk_rd = 1'b0;
            end
            if (chk_wr) begin
                compare("wr_busy", wr_busy, 1'b0);
                chk_wr = 1'b0;
            end
            if (!got_rd && rd_done) begin
                compare("rd_line", rd_line, exp_line);
                compare("rd_word", rd_word, exp_word);
                compare("rd_err", rd_err, exp_rd_err);
                compare("rd_busy", rd_busy, 1'b1);
                got_rd = 1'b1;
                chk_rd = 1'b1;
            end
            if (!got_wr && wr_done) begin
                compare("wr_err", wr_err, exp_wr_err);
                compare("wr_busy", wr_busy, 1'b1);
                got_wr = 1'b1;
                chk_wr = 1'b1;
            end
            if (n == TIMEOUT) begin
                $display("timed out waiting for rd_done or wr_done");
                stop_run();
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic issue(input logic do_rd, input logic do_wr);
        wait_idle(do_rd, do_wr);
        rd_req = do_rd;                 // both strobes on the same edge when paired
        wr_req = do_wr;
        @(negedge clk);
        rd_req = 1'b0;
        wr_req = 1'b0;
        if (do_rd) compare("rd_busy", rd_busy, 1'b1);
        if (do_wr) compare("wr_busy", wr_busy, 1'b1);
        wait_done(do_rd, do_wr);
    endtask

    // line sized incr bursts of 4 byte beats from the line base
    always @(negedge clk) begin
        if (rstn && arvalid) begin
            compare("araddr", araddr, {rd_addr[`ADDR_W-1:4], 4'h0});
            compare("arlen", arlen, `LINE_WORDS - 1);
            compare("arsize", arsize, 3'd2);
            compare("arburst", arburst, 2'b01);
        end
        if (rstn && awvalid) begin
            compare("awaddr", awaddr, {wr_addr[`ADDR_W-1:4], 4'h0});
            compare("awlen", awlen, `LINE_WORDS - 1);
            compare("awsize", awsize, 3'd2);
            compare("awburst", awburst, 2'b01);
        end
        if (rstn && wvalid)
            compare("wstrb", wstrb, 4'hf);   // whole line written
    end

    initial begin
        int                 fd, n, ops;
        string              text;
        logic [3:0]         op, eerr;
        logic [`ADDR_W-1:0] addr;
        logic [`LINE_W-1:0] wline, eline;
        logic [`DATA_W-1:0] eword;
        logic               pend_wr;
        clk     = 1'b0;
        rstn    = 1'b0;
        rd_req  = 1'b0;
        wr_req  = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        wr_line = '0;
        pend_wr = 1'b0;
        ops     = 0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        repeat (3) begin                // idle before any request
            @(negedge clk);
            compare("rd_busy", rd_busy, 1'b0);
            compare("wr_busy", wr_busy, 1'b0);
        end
        fd = $fopen("bench/l2_axi_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            stop_run();
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h", op, addr, wline, eline, eword, eerr);
            if (n != 6) begin
                $display("malformed test data line: %s", text);
                stop_run();
            end
            if (op == 4'd2) begin       // held for the next read
                wr_addr    = addr;
                wr_line    = wline;
                exp_wr_err = eerr[0];
                pend_wr    = 1'b1;
            end else if (op == 4'd1) begin
                wr_addr    = addr;
                wr_line    = wline;
                exp_wr_err = eerr[0];
                issue(1'b0, 1'b1);
            end else begin
                rd_addr    = addr;
                exp_line   = eline;
                exp_word   = eword;
                exp_rd_err = eerr[0];
                issue(1'b1, pend_wr);
                pend_wr    = 1'b0;
            end
            ops++;
        end
        $fclose(fd);
        if (ops == 0 || pend_wr) begin
            $display("test data file holds no complete operation list");
            stop_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- bench/l2_axi_testdata.txt
# op (0 read, 1 write, 2 write issued with the next read), address, write line,
# expected line, expected critical word, expected error flag; all hex, unused fields 0
0 00001000 0 0000100c000010080000100400001000 00001000 0
0 00002469 0 0000246c000024680000246400002460 00002468 0
1 00003000 deadbeefcafef00d0123456789abcdef 0 0 0
0 0000300c 0 deadbeefcafef00d0123456789abcdef deadbeef 0
0 80000040 0 8000004c800000488000004480000040 80000040 1
1 80000100 0123456789abcdef0123456789abcdef 0 0 1
2 00004000 11111111222222223333333344444444 0 0 0
0 00005004 0 0000500c000050080000500400005000 00005004 0
0 00004008 0 11111111222222223333333344444444 22222222 0

//--- list.f
+incdir+src
src/axi_pkg.sv
src/l2_pkg.sv
src/l2_req_decode.sv
src/axi_rd_engine.sv
src/axi_wr_engine.sv
src/l2_resp_collect.sv
src/l2_axi_bridge.sv
bench/axi_mem_model.sv
bench/tb_l2_axi_bridge.sv

//--- run_sim.sh
#!/bin/bash
# build and run the bridge testbench with verilator
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_l2_axi_bridge -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
